// ==== filelist.f ====
verilog/hist_pkg.sv
verilog/tdc_bin_mapper.sv
verilog/hist_ctrl.sv
verilog/hist_bank.sv
verilog/hist_readout.sv
verilog/hist_top.sv
verif/hist_checker.sv
verif/hist_tb.sv

// ==== verif/hist_checker.sv ====
`timescale 1ns/1ps

module hist_checker #(
    parameter int HITS_PER_HIST = 200,
    parameter int BIN_SHIFT = 6
) (
    input  logic                        clk,
    input  logic                        res,
    input  logic                        hit_valid,
    input  hist_pkg::hit_t              hit,
    input  logic [hist_pkg::TDC_W-1:0]  cal_offset,
    input  logic                        out_valid,
    input  hist_pkg::hist_word_t        out_word,
    input  logic                        hist_done,
    input  logic [15:0]                 dropped_hits,
    output int                          errors,
    output int                          words,
    output int                          hists,
    output int                          pending
);

    localparam int NUM_BINS = hist_pkg::NUM_BINS;
    localparam int BIN_W = hist_pkg::BIN_W;
    localparam int COUNT_W = hist_pkg::COUNT_W;
    localparam int COUNT_MAX = (1 << COUNT_W) - 1;

    // model banks
    int                   bank_m [2][NUM_BINS];
    // expected words and the cycles they are due in
    hist_pkg::hist_word_t exp_word [$];
    int                   exp_cyc [$];
    int                   done_cyc [$];
    hist_pkg::hist_word_t word_q;
    int                   cyc_q;
    int                   cyc;
    // cycles since reset release
    int                   rcnt;
    // last cycle that is not idle
    int                   busy_end;
    int                   hit_cnt;
    int                   pend_bin;
    int                   tgt;
    logic                 pend_vld;
    logic                 cap;
    // filled bank waiting for the readout
    logic                 full;
    logic                 full_armed;
    logic                 full_n;
    logic                 swap_late;
    logic [15:0]          exp_drop;

    // subtract, clamp at 0, shift, clamp at the last bin
    function automatic int bin_of(input logic [hist_pkg::TDC_W-1:0] code,
                                  input logic [hist_pkg::TDC_W-1:0] off);
        int corr;
        corr = int'(code) - int'(off);
        if (corr < 0) begin
            corr = 0;
        end
        corr = corr >> BIN_SHIFT;
        return (corr > NUM_BINS - 1) ? NUM_BINS - 1 : corr;
    endfunction

    // snapshot and clear a bank
    // words start at rs+2 and done follows the last one
    task automatic queue_readout(input logic bank, input int rs);
        for (int b = 0; b < NUM_BINS; b++) begin
            word_q.bin = BIN_W'(b);
            word_q.count = COUNT_W'(bank_m[bank][b]);
            exp_word.push_back(word_q);
            exp_cyc.push_back(rs + 2 + b);
            bank_m[bank][b] = 0;
        end
        done_cyc.push_back(rs + NUM_BINS + 2);
        // busy runs through hist_done
        busy_end = rs + NUM_BINS + 2;
    endtask

    always @(negedge clk) begin
        cyc = cyc + 1;
        if (!res) begin
            for (int b = 0; b < NUM_BINS; b++) begin
                bank_m[0][b] = 0;
                bank_m[1][b] = 0;
            end
            exp_word.delete();
            exp_cyc.delete();
            done_cyc.delete();
            rcnt = 0;
            hit_cnt = 0;
            busy_end = -1;
            pend_vld = 1'b0;
            cap = 1'b0;
            full = 1'b0;
            full_armed = 1'b0;
            exp_drop = '0;
        end else begin
            if (dropped_hits !== exp_drop) begin
                errors++;
                $display("[ERROR] dropped_hits exp %h got %h", exp_drop, dropped_hits);
            end
            // word due this cycle
            if (exp_cyc.size() > 0 && exp_cyc[0] == cyc) begin
                cyc_q = exp_cyc.pop_front();
                word_q = exp_word.pop_front();
                if (out_valid !== 1'b1) begin
                    errors++;
                    $display("out_valid missing for bin %0d at cycle %0d", word_q.bin, cyc_q);
                end else begin
                    words++;
                    if (out_word.bin !== word_q.bin) begin
                        errors++;
                        $display("[ERROR] out_word.bin exp %h got %h", word_q.bin, out_word.bin);
                    end
                    if (out_word.count !== word_q.count) begin
                        errors++;
                        $display("[ERROR] out_word.count exp %h got %h (bin %0d)",
                                 word_q.count, out_word.count, word_q.bin);
                    end
                end
            end else if (out_valid !== 1'b0) begin
                errors++;
                $display("out_valid raised with no word due at cycle %0d", cyc);
            end
            if (done_cyc.size() > 0 && done_cyc[0] == cyc) begin
                cyc_q = done_cyc.pop_front();
                if (hist_done !== 1'b1) begin
                    errors++;
                    $display("hist_done missing at cycle %0d", cyc_q);
                end else begin
                    hists++;
                end
            end else if (hist_done !== 1'b0) begin
                errors++;
                $display("hist_done raised outside a readout at cycle %0d", cyc);
            end

            // deferred swap once the readout has ended
            swap_late = full && full_armed && (cyc > busy_end);
            full_n = full;
            // mapped hit from one cycle back is ignored during the sweep
            if (pend_vld && rcnt >= NUM_BINS) begin
                if (full && !swap_late) begin
                    if (exp_drop != 16'hffff) begin
                        exp_drop++;
                    end
                end else begin
                    // first hit after a late swap goes to the new bank
                    tgt = swap_late ? !cap : cap;
                    if (bank_m[tgt][pend_bin] < COUNT_MAX) begin
                        bank_m[tgt][pend_bin]++;
                    end
                    if (swap_late) begin
                        hit_cnt = 1;
                    end else if (hit_cnt == HITS_PER_HIST - 1) begin
                        hit_cnt = 0;
                        if (cyc > busy_end) begin
                            // increment goes out next cycle and rd_start 2 after that
                            queue_readout(cap, cyc + 3);
                            cap = !cap;
                        end else begin
                            full_n = 1'b1;
                        end
                    end else begin
                        hit_cnt++;
                    end
                end
            end
            if (swap_late) begin
                queue_readout(cap, cyc + 1);
                cap = !cap;
                full_n = 1'b0;
            end
            full_armed = full;
            full = full_n;
            pend_vld = hit_valid;
            pend_bin = bin_of(hit.tdc_code, cal_offset);
            rcnt++;
        end
        pending = exp_cyc.size() + done_cyc.size();
    end

endmodule

// ==== verif/hist_tb.sv ====
`timescale 1ns/1ps

module hist_tb;

    localparam int NUM_BINS = hist_pkg::NUM_BINS;
    // small histograms so dense bursts overrun the readout
    localparam int HITS = 48;
    // late codes clamp at the last bin with this shift
    localparam int SHIFT = 5;
    // more hits on one bin than a count can hold
    localparam int SAT_HITS = 66000;
    localparam int SPARSE_HITS = 150;
    localparam int DENSE_HITS = 400;
    localparam int MAX_GAP = 9;
    localparam int RUN_HITS = 12 + 2 * SPARSE_HITS + DENSE_HITS;
    // doubled hits, both runs in series, every readout window, margin
    localparam int WD_CYCLES = 2 * RUN_HITS * MAX_GAP + SAT_HITS
                             + (2 * RUN_HITS / HITS + 4) * (NUM_BINS + 8) + 2000;

    logic                       clk = 1'b0;
    logic                       res;
    logic                       hit_valid;
    hist_pkg::hit_t             hit;
    logic [hist_pkg::TDC_W-1:0] cal_offset;
    logic                       out_valid;
    hist_pkg::hist_word_t       out_word;
    logic                       hist_done;
    logic [15:0]                dropped_hits;
    // saturation configuration
    logic                       sat_valid;
    hist_pkg::hit_t             sat_hit;
    logic [hist_pkg::TDC_W-1:0] sat_offset;
    logic                       sat_out_valid;
    hist_pkg::hist_word_t       sat_out_word;
    logic                       sat_hist_done;
    logic [15:0]                sat_dropped;
    int                         run_err;
    int                         run_words;
    int                         run_hists;
    int                         run_pend;
    int                         sat_err;
    int                         sat_words;
    int                         sat_hists;
    int                         sat_pend;
    int unsigned                lcg_state = 95;
    logic                       run_end = 1'b0;
    logic                       sat_end = 1'b0;

    always #4 clk = ~clk;

    hist_top #(.HITS_PER_HIST(HITS), .BIN_SHIFT(SHIFT)) uut (
        .clk(clk), .res(res), .hit_valid(hit_valid), .hit(hit), .cal_offset(cal_offset),
        .out_valid(out_valid), .out_word(out_word), .hist_done(hist_done),
        .dropped_hits(dropped_hits)
    );

    hist_checker #(.HITS_PER_HIST(HITS), .BIN_SHIFT(SHIFT)) chk (
        .clk(clk), .res(res), .hit_valid(hit_valid), .hit(hit), .cal_offset(cal_offset),
        .out_valid(out_valid), .out_word(out_word), .hist_done(hist_done),
        .dropped_hits(dropped_hits), .errors(run_err), .words(run_words),
        .hists(run_hists), .pending(run_pend)
    );

    hist_top #(.HITS_PER_HIST(SAT_HITS), .BIN_SHIFT(SHIFT)) uut_sat (
        .clk(clk), .res(res), .hit_valid(sat_valid), .hit(sat_hit), .cal_offset(sat_offset),
        .out_valid(sat_out_valid), .out_word(sat_out_word), .hist_done(sat_hist_done),
        .dropped_hits(sat_dropped)
    );

    hist_checker #(.HITS_PER_HIST(SAT_HITS), .BIN_SHIFT(SHIFT)) chk_sat (
        .clk(clk), .res(res), .hit_valid(sat_valid), .hit(sat_hit), .cal_offset(sat_offset),
        .out_valid(sat_out_valid), .out_word(sat_out_word), .hist_done(sat_hist_done),
        .dropped_hits(sat_dropped), .errors(sat_err), .words(sat_words),
        .hists(sat_hists), .pending(sat_pend)
    );

    // 32-bit LCG, upper bits are the better ones
    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state >> 8;
    endfunction

    // one hit, then gap-1 quiet cycles
    task automatic send_hit(input logic [hist_pkg::TDC_W-1:0] code, input int gap);
        @(posedge clk);
        hit_valid <= 1'b1;
        hit.tdc_code <= code;
        repeat (gap - 1) begin
            @(posedge clk);
            hit_valid <= 1'b0;
        end
    endtask

    task automatic quiet(input int n);
        repeat (n) begin
            @(posedge clk);
            hit_valid <= 1'b0;
        end
    endtask

    task automatic random_hits(input int n, input int min_gap, input int max_gap);
        logic [hist_pkg::TDC_W-1:0] code;
        int unsigned sel;
        int gap;
        for (int i = 0; i < n; i++) begin
            sel = next_rand() % 16;
            gap = min_gap + int'(next_rand() % (max_gap - min_gap + 1));
            code = hist_pkg::TDC_W'(next_rand());
            // extreme codes now and then
            if (sel == 0) begin
                code = '0;
            end else if (sel == 1) begin
                code = '1;
            end
            // same bin twice back to back
            if (sel == 2) begin
                send_hit(code, 1);
            end
            send_hit(code, gap);
        end
    endtask

    initial begin : stimulus
        res = 1'b0;
        hit_valid = 1'b0;
        hit = '0;
        cal_offset = '0;
        repeat (5) @(posedge clk);
        res <= 1'b1;
        // lands in the post-reset sweep, must not count
        random_hits(12, 2, 3);
        quiet(NUM_BINS);
        // sparse phases, new offset each
        for (int p = 0; p < 2; p++) begin
            cal_offset <= hist_pkg::TDC_W'(next_rand() % 1024);
            random_hits(SPARSE_HITS, 2, MAX_GAP);
            quiet(4);
        end
        // bursts fill a bank while the other one is read
        cal_offset <= hist_pkg::TDC_W'(next_rand() % 1024);
        random_hits(DENSE_HITS, 1, 2);
        quiet(3 * NUM_BINS);
        run_end = 1'b1;
    end

    initial begin : sat_stimulus
        sat_valid = 1'b0;
        sat_hit = '0;
        sat_offset = 12'h020;
        @(posedge res);
        repeat (NUM_BINS + 4) @(posedge clk);
        // one code back to back, all into bin 8
        sat_valid <= 1'b1;
        sat_hit.tdc_code <= 12'h123;
        repeat (SAT_HITS) @(posedge clk);
        sat_valid <= 1'b0;
        repeat (3 * NUM_BINS) @(posedge clk);
        sat_end = 1'b1;
    end

    initial begin : report
        int total;
        wait (run_end && sat_end);
        wait (run_pend == 0 && sat_pend == 0);
        @(posedge clk);
        total = run_err + sat_err;
        if (sat_hists != 1) begin
            $display("saturation run gave %0d histograms instead of 1", sat_hists);
            total++;
        end
        if (dropped_hits == 16'd0) begin
            $display("dense phase dropped no hits");
            total++;
        end
        $display("words %0d, histograms %0d, dropped hits %0d, errors %0d",
                 run_words + sat_words, run_hists + sat_hists, dropped_hits, total);
        if (total == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(WD_CYCLES * 8);
        $display("timeout, run did not finish within %0d cycles", WD_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== verilog/hist_bank.sv ====
`timescale 1ns/1ps

module hist_bank (
    input  logic                        clk,
    input  logic                        res,
    input  logic                        inc_valid,
    input  hist_pkg::bin_upd_t          inc,
    input  logic                        clr_valid,
    input  hist_pkg::bank_t             clr_bank,
    input  logic [hist_pkg::BIN_W-1:0]  clr_bin,
    output hist_pkg::hist_word_t        rd_word
);

    localparam int BIN_W = hist_pkg::BIN_W;
    localparam int COUNT_W = hist_pkg::COUNT_W;
    localparam int NUM_BINS = hist_pkg::NUM_BINS;

    // two ping-pong count arrays
    logic [COUNT_W-1:0] mem [2][NUM_BINS];

    logic [BIN_W:0]     sweep_cnt;
    logic               sweeping;

    // stage 1 reads, stage 2 writes
    logic               s1_vld;
    hist_pkg::bin_upd_t s1_upd;
    logic               s2_vld;
    hist_pkg::bin_upd_t s2_upd;
    logic [COUNT_W-1:0] s2_cnt;
    logic [COUNT_W-1:0] s2_next;
    logic               fwd;

    // clear stage
    logic               clr_q_vld;
    hist_pkg::bank_t    clr_q_bank;
    logic [BIN_W-1:0]   clr_q_bin;

    assign sweeping = !sweep_cnt[BIN_W];

    // saturating increment
    assign s2_next = (&s2_cnt) ? s2_cnt : s2_cnt + 1'b1;
    // same bin back to back, take the value being written
    assign fwd = s2_vld && (s2_upd == s1_upd);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            sweep_cnt <= '0;
            s1_vld <= 1'b0;
            s2_vld <= 1'b0;
            clr_q_vld <= 1'b0;
        end else begin
            if (sweeping) begin
                sweep_cnt <= sweep_cnt + 1'b1;
            end
            s1_vld <= inc_valid;
            s2_vld <= s1_vld;
            clr_q_vld <= clr_valid;
        end
    end

    // pipeline payload
    always_ff @(posedge clk) begin
        s1_upd <= inc;
        s2_upd <= s1_upd;
        if (fwd) begin
            s2_cnt <= s2_next;
        end else begin
            s2_cnt <= mem[s1_upd.bank][s1_upd.bin];
        end
        clr_q_bank <= clr_bank;
        clr_q_bin <= clr_bin;
    end

    always_ff @(posedge clk) begin
        if (sweeping) begin
            // zero one bin of each bank per cycle
            mem[0][sweep_cnt[BIN_W-1:0]] <= '0;
            mem[1][sweep_cnt[BIN_W-1:0]] <= '0;
        end else begin
            if (s2_vld) begin
                mem[s2_upd.bank][s2_upd.bin] <= s2_next;
            end
            // read and clear
            if (clr_q_vld) begin
                mem[clr_q_bank][clr_q_bin] <= '0;
            end
        end
    end

    // old count, one cycle after the clear request
    assign rd_word.bin = clr_q_bin;
    assign rd_word.count = mem[clr_q_bank][clr_q_bin];

    // readout only touches a bank whose increments have all committed
    a_bank_no_overlap : assert property (
        @(posedge clk) disable iff (!res)
        clr_q_vld |-> !(s1_vld && (s1_upd.bank == clr_q_bank))
                   && !(s2_vld && (s2_upd.bank == clr_q_bank))
    );

endmodule

// ==== verilog/hist_ctrl.sv ====
`timescale 1ns/1ps

module hist_ctrl #(
    parameter int HITS_PER_HIST = 200
) (
    input  logic                        clk,
    input  logic                        res,
    input  logic                        map_valid,
    input  logic [hist_pkg::BIN_W-1:0]  map_bin,
    input  logic                        busy,
    output logic                        inc_valid,
    output hist_pkg::bin_upd_t          inc,
    output logic                        rd_start,
    output hist_pkg::bank_t             rd_bank,
    output logic [15:0]                 dropped_hits
);

    localparam int BIN_W = hist_pkg::BIN_W;
    localparam int CNT_W = $clog2(HITS_PER_HIST + 1);

    // post-reset window while the banks are swept to zero
    logic [BIN_W:0]     sweep_cnt;
    logic               sweep_done;

    logic [CNT_W-1:0]   hit_cnt;
    hist_pkg::bank_t    cap_bank;
    // bank filled but readout still running
    logic               full;
    logic               full_armed;
    // commit delay for the last increment
    logic [1:0]         start_pipe;

    logic               idle;
    logic               last_hit;
    logic               accept;
    logic               drop;
    logic               swap_now;
    logic               swap_late;

    assign sweep_done = sweep_cnt[BIN_W];
    // readout neither running nor scheduled
    assign idle = !busy && (start_pipe == 2'b00);
    assign last_hit = (hit_cnt == CNT_W'(HITS_PER_HIST - 1));

    // deferred swap once the readout is gone
    // full_armed keeps the final increment committed before the clear starts
    assign swap_late = full && full_armed && idle;

    assign accept = sweep_done && map_valid && (!full || swap_late);
    assign drop = sweep_done && map_valid && full && !swap_late;
    // immediate swap on the last hit while idle
    assign swap_now = accept && !full && last_hit && idle;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            sweep_cnt <= '0;
        end else if (!sweep_done) begin
            sweep_cnt <= sweep_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            hit_cnt <= '0;
            cap_bank <= 1'b0;
            rd_bank <= 1'b0;
            full <= 1'b0;
            full_armed <= 1'b0;
            start_pipe <= 2'b00;
            rd_start <= 1'b0;
            inc_valid <= 1'b0;
            dropped_hits <= '0;
        end else begin
            inc_valid <= accept;
            full_armed <= full;
            start_pipe <= {start_pipe[0], swap_now};
            // late swap needs no commit wait
            rd_start <= start_pipe[1] | swap_late;

            if (accept) begin
                if (swap_late) begin
                    // this hit is the first one of the new bank
                    hit_cnt <= CNT_W'(1);
                end else if (last_hit) begin
                    hit_cnt <= '0;
                end else begin
                    hit_cnt <= hit_cnt + 1'b1;
                end
            end

            // bank done but previous readout busy
            if (accept && !full && last_hit && !idle) begin
                full <= 1'b1;
            end else if (swap_late) begin
                full <= 1'b0;
            end

            // old bank goes to the readout
            if (swap_now || swap_late) begin
                cap_bank <= ~cap_bank;
                rd_bank <= cap_bank;
            end

            if (drop && (dropped_hits != '1)) begin
                dropped_hits <= dropped_hits + 1'b1;
            end
        end
    end

    // increment payload, last hit still targets the old bank
    always_ff @(posedge clk) begin
        if (accept) begin
            inc.bin <= map_bin;
            inc.bank <= cap_bank ^ swap_late;
        end
    end

    // a new readout starts only after the previous one has ended
    a_start_when_idle : assert property (
        @(posedge clk) disable iff (!res)
        rd_start |-> !$past(busy)
    );

endmodule

// ==== verilog/hist_pkg.sv ====
package hist_pkg;

    // timestamp code width from the TDC
    localparam int TDC_W = 12;

    // bin index width, 64 bins
    localparam int BIN_W = 6;
    localparam int NUM_BINS = 2 ** BIN_W;

    // per-bin count, saturates at all ones
    localparam int COUNT_W = 16;

    // selects one of the two ping-pong banks
    typedef logic bank_t;

    // one raw hit from the TDC
    typedef struct packed {
        logic [TDC_W-1:0] tdc_code;
    } hit_t;

    // one increment request toward the banks
    typedef struct packed {
        logic [BIN_W-1:0] bin;
        bank_t            bank;
    } bin_upd_t;

    // one word of a streamed histogram
    typedef struct packed {
        logic [BIN_W-1:0]   bin;
        logic [COUNT_W-1:0] count;
    } hist_word_t;

endpackage

// ==== verilog/hist_readout.sv ====
`timescale 1ns/1ps

module hist_readout (
    input  logic                        clk,
    input  logic                        res,
    input  logic                        rd_start,
    input  hist_pkg::bank_t             rd_bank,
    input  hist_pkg::hist_word_t        rd_word,
    output logic                        clr_valid,
    output hist_pkg::bank_t             clr_bank,
    output logic [hist_pkg::BIN_W-1:0]  clr_bin,
    output logic                        busy,
    output logic                        out_valid,
    output hist_pkg::hist_word_t        out_word,
    output logic                        hist_done
);

    localparam int BIN_W = hist_pkg::BIN_W;
    localparam logic [BIN_W-1:0] LAST_BIN = BIN_W'(hist_pkg::NUM_BINS - 1);

    // sweeping bins 1 to last, bin 0 goes out with rd_start
    logic               active;
    logic [BIN_W-1:0]   bin_cnt;
    hist_pkg::bank_t    bank_q;
    // bank data valid this cycle
    logic               rd_vld;

    assign clr_valid = rd_start | active;
    assign clr_bank = active ? bank_q : rd_bank;
    assign clr_bin = active ? bin_cnt : '0;

    // from rd_start through hist_done
    assign busy = rd_start | active | rd_vld | out_valid | hist_done;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            active <= 1'b0;
            bin_cnt <= '0;
            bank_q <= 1'b0;
            rd_vld <= 1'b0;
            out_valid <= 1'b0;
            hist_done <= 1'b0;
        end else begin
            rd_vld <= clr_valid;
            out_valid <= rd_vld;
            // pulse after the last word
            hist_done <= out_valid && (out_word.bin == LAST_BIN);

            if (rd_start) begin
                active <= 1'b1;
                bin_cnt <= BIN_W'(1);
                bank_q <= rd_bank;
            end else if (active) begin
                bin_cnt <= bin_cnt + 1'b1;
                if (bin_cnt == LAST_BIN) begin
                    active <= 1'b0;
                end
            end
        end
    end

    // output word register
    always_ff @(posedge clk) begin
        if (rd_vld) begin
            out_word <= rd_word;
        end
    end

endmodule

// ==== verilog/hist_top.sv ====
`timescale 1ns/1ps

module hist_top #(
    parameter int HITS_PER_HIST = 200,
    parameter int BIN_SHIFT = 6
) (
    input  logic                        clk,
    input  logic                        res,
    input  logic                        hit_valid,
    input  hist_pkg::hit_t              hit,
    input  logic [hist_pkg::TDC_W-1:0]  cal_offset,
    output logic                        out_valid,
    output hist_pkg::hist_word_t        out_word,
    output logic                        hist_done,
    output logic [15:0]                 dropped_hits
);

    // mapper to ctrl
    logic                       map_valid;
    logic [hist_pkg::BIN_W-1:0] map_bin;

    // ctrl to bank
    logic                       inc_valid;
    hist_pkg::bin_upd_t         inc;

    // ctrl and readout
    logic                       rd_start;
    hist_pkg::bank_t            rd_bank;
    logic                       busy;

    // readout and bank
    logic                       clr_valid;
    hist_pkg::bank_t            clr_bank;
    logic [hist_pkg::BIN_W-1:0] clr_bin;
    hist_pkg::hist_word_t       rd_word;

    tdc_bin_mapper #(
        .BIN_SHIFT (BIN_SHIFT)
    ) u_mapper (
        .clk        (clk),
        .res        (res),
        .hit_valid  (hit_valid),
        .hit        (hit),
        .cal_offset (cal_offset),
        .map_valid  (map_valid),
        .map_bin    (map_bin)
    );

    hist_ctrl #(
        .HITS_PER_HIST (HITS_PER_HIST)
    ) u_ctrl (
        .clk          (clk),
        .res          (res),
        .map_valid    (map_valid),
        .map_bin      (map_bin),
        .busy         (busy),
        .inc_valid    (inc_valid),
        .inc          (inc),
        .rd_start     (rd_start),
        .rd_bank      (rd_bank),
        .dropped_hits (dropped_hits)
    );

    hist_bank u_bank (
        .clk       (clk),
        .res       (res),
        .inc_valid (inc_valid),
        .inc       (inc),
        .clr_valid (clr_valid),
        .clr_bank  (clr_bank),
        .clr_bin   (clr_bin),
        .rd_word   (rd_word)
    );

    hist_readout u_readout (
        .clk       (clk),
        .res       (res),
        .rd_start  (rd_start),
        .rd_bank   (rd_bank),
        .rd_word   (rd_word),
        .clr_valid (clr_valid),
        .clr_bank  (clr_bank),
        .clr_bin   (clr_bin),
        .busy      (busy),
        .out_valid (out_valid),
        .out_word  (out_word),
        .hist_done (hist_done)
    );

endmodule

// ==== verilog/tdc_bin_mapper.sv ====
`timescale 1ns/1ps

module tdc_bin_mapper #(
    parameter int BIN_SHIFT = 6
) (
    input  logic                        clk,
    input  logic                        res,
    input  logic                        hit_valid,
    input  hist_pkg::hit_t              hit,
    input  logic [hist_pkg::TDC_W-1:0]  cal_offset,
    output logic                        map_valid,
    output logic [hist_pkg::BIN_W-1:0]  map_bin
);

    localparam int TDC_W = hist_pkg::TDC_W;
    localparam int BIN_W = hist_pkg::BIN_W;

    // one extra bit catches the borrow
    logic [TDC_W:0]   diff;
    logic [TDC_W-1:0] corr;
    logic [TDC_W-1:0] shifted;
    logic [BIN_W-1:0] bin_next;

    always_comb begin
        diff = {1'b0, hit.tdc_code} - {1'b0, cal_offset};
        // hit earlier than the offset lands in bin 0
        corr = diff[TDC_W] ? '0 : diff[TDC_W-1:0];
        shifted = corr >> BIN_SHIFT;
        // late hits pile up in the last bin
        if (shifted > TDC_W'(hist_pkg::NUM_BINS - 1)) begin
            bin_next = BIN_W'(hist_pkg::NUM_BINS - 1);
        end else begin
            bin_next = shifted[BIN_W-1:0];
        end
    end

    // strobe one cycle behind hit_valid
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            map_valid <= 1'b0;
        end else begin
            map_valid <= hit_valid;
        end
    end

    // bin index only loads with a hit
    always_ff @(posedge clk) begin
        if (hit_valid) begin
            map_bin <= bin_next;
        end
    end

    // a mapped strobe always carries a defined bin
    a_map_bin_known : assert property (
        @(posedge clk) disable iff (!res)
        map_valid |-> !$isunknown(map_bin)
    );

endmodule
